// File: wisc_top.f
+incdir+common
common/wisc_pkg.sv
logic/pipe_stage_reg.sv
fetch/fetch_stage.sv
decode/decode_stage.sv
execute/execute_stage.sv
logic/mem_stage.sv
logic/host_ctrl_regs.sv
wisc_top.sv
dv/tb_clock_gen.sv
dv/wisc_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the WISC testbench with Verilator, run it, and decide on the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module wisc_tb -f wisc_top.f \
	--Mdir obj_dir -o wisc_sim > build.log 2>&1 || cat build.log
[ -x obj_dir/wisc_sim ] && ./obj_dir/wisc_sim | tee sim.log
grep -qx 'PASS: all tests' sim.log 2>/dev/null && exit 0 || { echo 'simulation failed'; exit 1; }

// File: dv/wisc_tb.sv
// WISC testbench: APB host driver, reference interpreter and directed program tests
`timescale 1ns/10ps
`default_nettype none

`include "wisc_consts.svh"

module wisc_tb;
	import wisc_pkg::*;

	logic               clk, rst;
	logic               psel, penable, pwrite;
	logic [`APB_AW-1:0] paddr;
	logic [`WORD_W-1:0] pwdata, prdata;
	logic               pready, pslverr;

	logic [`WORD_W-1:0] prog [$]; // Program image under test
	logic [`WORD_W-1:0] ref_regs [2**`REG_AW]; // Model register file, persists across programs
	logic [`WORD_W-1:0] ref_dmem [2**`DMEM_AW];
	logic [31:0]        lcg_state = 32'h5d6a89bc;
	int                 n_checks, n_errors, n_tests;
	int                 budget = 100; // Watchdog cycles, reset plus map test
	int                 elapsed;

	tb_clock_gen #(.period_ns(4), .rst_cycles(3)) tb_clock_gen_inst (.clk, .rst);

	wisc_top wisc_top_inst (.clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr);

	function automatic logic [`WORD_W-1:0] rand_word();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:16]; // Upper bits are the better ones
	endfunction

	task automatic compare_word(input string name, input logic [`WORD_W-1:0] got,
		input logic [`WORD_W-1:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic compare_word_min(input string name, input logic [`WORD_W-1:0] got,
		input logic [`WORD_W-1:0] min_exp);
		n_checks++;
		if ($isunknown(got) || got < min_exp) begin
			n_errors++;
			$display("ERROR %s got 0x%h expected at least 0x%h", name, got, min_exp);
		end
	endtask

	task automatic compare_flag(input string name, input logic got, input logic exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic note_failure(input string what);
		n_checks++;
		n_errors++;
		$display("%s", what);
	endtask

	task automatic finish_test(input string name, input int errs_before);
		n_tests++;
		if (n_errors == errs_before) $display("test %s: ok", name);
		else $display("test %s: %0d errors", name, n_errors - errs_before);
	endtask

	// One APB transfer: setup cycle, access cycle, then idle
	task automatic bus_cycle(input logic wr, input logic [`APB_AW-1:0] addr,
		input logic [`WORD_W-1:0] wdata, output logic [`WORD_W-1:0] rdata, output logic err);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= wr;
		paddr <= addr;
		pwdata <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk); // Mid access phase
		rdata = prdata;
		err = pslverr;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_write(input logic [`APB_AW-1:0] addr, input logic [`WORD_W-1:0] data);
		logic [`WORD_W-1:0] rdata;
		logic               err;
		bus_cycle(1'b1, addr, data, rdata, err);
		compare_flag("pslverr", err, 1'b0);
	endtask

	task automatic apb_read(input logic [`APB_AW-1:0] addr, output logic [`WORD_W-1:0] data);
		logic err;
		bus_cycle(1'b0, addr, '0, data, err);
		compare_flag("pslverr", err, 1'b0);
	endtask

	// Instruction encoders, fields per the ISA formats
	function automatic logic [`WORD_W-1:0] alu_word(input opcode_e op,
		input logic [3:0] rd, input logic [3:0] rs, input logic [3:0] rt);
		return {op, rd, rs, rt}; // Also LW/SW with rt, base, off4
	endfunction

	function automatic logic [`WORD_W-1:0] imm_word(input opcode_e op, input logic [3:0] rd,
		input logic [7:0] imm);
		return {op, rd, imm};
	endfunction

	function automatic logic [`WORD_W-1:0] branch_word(input br_cond_e cond,
		input logic [1:0] tested, input logic [7:0] off);
		return {OP_B, cond, tested, off};
	endfunction

	task automatic put_const(input logic [3:0] rd, input logic [`WORD_W-1:0] value);
		prog.push_back(imm_word(OP_LLB, rd, value[7:0]));
		prog.push_back(imm_word(OP_LHB, rd, value[15:8])); // Overwrites the high byte
	endtask

	// Execution at up to 8 cycles per word, APB traffic at 4 cycles per transfer
	task automatic extend_budget(input int words);
		budget += words * 8 + 4 * (3 * words + 48);
	endtask

	// Sequential ISA model, counts every retired instruction but HLT
	task automatic run_reference(output int retired);
		logic [`WORD_W-1:0] ins, a, b, res, addr, tested;
		logic [`REG_AW-1:0] rd;
		logic               writes, done, taken;
		int                 pc, steps;
		pc = 0;
		retired = 0;
		done = 1'b0;
		for (steps = 0; steps < 1000 && !done; steps++) begin
			ins = prog[pc];
			rd = ins[11:8];
			a = ref_regs[ins[7:4]];
			b = ref_regs[ins[3:0]];
			addr = a + {{12{ins[3]}}, ins[3:0]}; // Base plus signed offset
			tested = ref_regs[ins[9:8]]; // Branches see r0..r3 only
			writes = 1'b1;
			res = '0;
			pc++;
			case (opcode_e'(ins[15:12]))
				OP_ADD: res = a + b;
				OP_SUB: res = a - b;
				OP_AND: res = a & b;
				OP_NOR: res = ~(a | b);
				OP_SLL: res = a << ins[3:0];
				OP_SRL: res = a >> ins[3:0];
				OP_LW: res = ref_dmem[addr[`DMEM_AW-1:0]];
				OP_SW: begin
					ref_dmem[addr[`DMEM_AW-1:0]] = ref_regs[rd];
					writes = 1'b0;
				end
				OP_LLB: res = {ref_regs[rd][15:8], ins[7:0]};
				OP_LHB: res = {ins[7:0], ref_regs[rd][7:0]};
				OP_B: begin
					writes = 1'b0;
					taken = (ins[11:10] == 2'd2) || (ins[11:10] == 2'd0 && tested == '0)
						|| (ins[11:10] == 2'd1 && tested != '0);
					if (taken) pc = pc + $signed(ins[7:0]); // pc already at next word
				end
				OP_HLT: begin
					done = 1'b1;
					writes = 1'b0;
				end
				default: writes = 1'b0;
			endcase
			if (!done) retired++;
			if (writes && rd != '0) ref_regs[rd] = res; // r0 stays zero
		end
	endtask

	task automatic run_to_halt();
		logic [`WORD_W-1:0] status;
		int                 polls;
		status = '0;
		polls = 0;
		while (!status[0] && polls < 2 * prog.size() + 8) begin
			apb_read(`REG_STATUS, status);
			polls++;
		end
		if (!status[0]) begin
			note_failure("processor did not halt within the poll limit");
			apb_write(`REG_CTRL, 16'h0000); // Stop it by hand
		end
	endtask

	task automatic check_against_model();
		logic [`WORD_W-1:0] value;
		int                 exp_retired;
		run_reference(exp_retired);
		for (int i = 0; i < 2**`REG_AW; i++) begin
			apb_write(`REG_DBG_SEL, i[`WORD_W-1:0]);
			apb_read(`REG_DBG_DATA, value);
			compare_word($sformatf("dbg_data(r%0d)", i), value, ref_regs[i]);
		end
		apb_read(`REG_RETIRED, value);
		compare_word("retired", value, exp_retired[`WORD_W-1:0]);
		apb_read(`REG_CYCLES, value); // One cycle per retired word, HLT included
		compare_word_min("cycles", value, exp_retired[`WORD_W-1:0] + 16'd1);
	endtask

	task automatic run_program();
		extend_budget(prog.size());
		apb_write(`REG_IMEM_ADDR, 16'h0000);
		foreach (prog[i]) apb_write(`REG_IMEM_DATA, prog[i]); // Address auto-increments
		apb_write(`REG_CTRL, 16'h0001); // Start from PC 0
		run_to_halt();
		check_against_model();
	endtask

	task automatic check_halted();
		logic [`WORD_W-1:0] value;
		apb_read(`REG_CTRL, value);
		compare_flag("ctrl.run", value[0], 1'b0);
		apb_read(`REG_STATUS, value);
		compare_flag("status.halted", value[0], 1'b1);
	endtask

	task automatic test_apb_map();
		logic [`WORD_W-1:0] value;
		logic               err;
		int                 errs;
		errs = n_errors;
		apb_read(`REG_CTRL, value);
		compare_word("ctrl", value, 16'h0000);
		apb_read(`REG_STATUS, value);
		compare_word("status", value, 16'h0000);
		apb_read(`REG_CYCLES, value);
		compare_word("cycles", value, 16'h0000);
		apb_read(`REG_RETIRED, value);
		compare_word("retired", value, 16'h0000);
		apb_write(`REG_IMEM_ADDR, 16'h005a);
		apb_read(`REG_IMEM_ADDR, value);
		compare_word("imem_addr", value, 16'h005a);
		apb_write(`REG_DBG_SEL, 16'h0009);
		apb_read(`REG_DBG_SEL, value);
		compare_word("dbg_sel", value, 16'h0009);
		bus_cycle(1'b0, 5'h02, '0, value, err); // Unmapped offset
		compare_flag("pslverr", err, 1'b1);
		bus_cycle(1'b1, `REG_STATUS, 16'h0001, value, err); // Read-only target
		compare_flag("pslverr", err, 1'b1);
		apb_read(`REG_STATUS, value);
		compare_word("status", value, 16'h0000);
		@(negedge clk);
		compare_flag("pready", pready, 1'b1);
		finish_test("apb_map", errs);
	endtask

	task automatic test_alu();
		logic [`WORD_W-1:0] amt;
		int                 errs;
		errs = n_errors;
		amt = rand_word();
		prog.delete();
		put_const(4'd1, rand_word());
		put_const(4'd2, rand_word());
		put_const(4'd3, rand_word());
		put_const(4'd4, rand_word());
		prog.push_back(alu_word(OP_ADD, 4'd5, 4'd1, 4'd2));
		prog.push_back(alu_word(OP_SUB, 4'd6, 4'd1, 4'd2));
		prog.push_back(alu_word(OP_AND, 4'd7, 4'd3, 4'd4));
		prog.push_back(alu_word(OP_NOR, 4'd8, 4'd3, 4'd4));
		prog.push_back(alu_word(OP_SLL, 4'd9, 4'd1, amt[3:0]));
		prog.push_back(alu_word(OP_SRL, 4'd10, 4'd2, amt[7:4]));
		prog.push_back(imm_word(OP_LLB, 4'd11, amt[15:8])); // Lone byte merges
		prog.push_back(imm_word(OP_LHB, 4'd12, amt[11:4]));
		prog.push_back(alu_word(OP_ADD, 4'd13, 4'd5, 4'd0)); // r0 source
		prog.push_back(alu_word(OP_ADD, 4'd0, 4'd1, 4'd2)); // Write to r0 dropped
		prog.push_back({OP_HLT, 12'h000});
		run_program();
		finish_test("alu_imm", errs);
	endtask

	task automatic test_load_store();
		int errs;
		errs = n_errors;
		prog.delete();
		put_const(4'd1, 16'h0040); // Base address
		put_const(4'd2, rand_word());
		put_const(4'd3, rand_word());
		prog.push_back(alu_word(OP_SW, 4'd2, 4'd1, 4'h0));
		prog.push_back(alu_word(OP_SW, 4'd3, 4'd1, 4'hf)); // Offset -1
		prog.push_back(alu_word(OP_SW, 4'd2, 4'd1, 4'h7));
		prog.push_back(alu_word(OP_SW, 4'd3, 4'd1, 4'h8)); // Offset -8
		prog.push_back(alu_word(OP_LW, 4'd4, 4'd1, 4'h0));
		prog.push_back(alu_word(OP_LW, 4'd5, 4'd1, 4'hf));
		prog.push_back(alu_word(OP_LW, 4'd6, 4'd1, 4'h7));
		prog.push_back(alu_word(OP_LW, 4'd7, 4'd1, 4'h8));
		prog.push_back({OP_HLT, 12'h000});
		run_program();
		finish_test("load_store", errs);
	endtask

	task automatic test_branches();
		int errs;
		errs = n_errors;
		prog.delete();
		put_const(4'd1, 16'h0000);
		put_const(4'd2, 16'h0005);
		prog.push_back(branch_word(BR_ZERO, 2'd1, 8'd2)); // pc 4, taken to 7
		prog.push_back(imm_word(OP_LLB, 4'd7, 8'hee)); // Shadow
		prog.push_back(imm_word(OP_LLB, 4'd8, 8'hee)); // Shadow
		prog.push_back(branch_word(BR_NZERO, 2'd1, 8'd2)); // Falls through
		prog.push_back(imm_word(OP_LLB, 4'd9, 8'h11));
		prog.push_back(branch_word(BR_NZERO, 2'd2, 8'd1)); // pc 9, taken to 11
		prog.push_back(imm_word(OP_LLB, 4'd10, 8'hee));
		prog.push_back(branch_word(BR_ZERO, 2'd2, 8'd1)); // Falls through
		prog.push_back(imm_word(OP_LLB, 4'd11, 8'h22));
		prog.push_back(branch_word(BR_ALWAYS, 2'd0, 8'd1)); // pc 13, taken to 15
		prog.push_back(imm_word(OP_LLB, 4'd12, 8'hee));
		prog.push_back(imm_word(OP_LLB, 4'd13, 8'h33));
		put_const(4'd3, 16'h0003); // Loop count
		put_const(4'd4, 16'h0001);
		prog.push_back(alu_word(OP_SUB, 4'd3, 4'd3, 4'd4));
		prog.push_back(branch_word(BR_NZERO, 2'd3, 8'hfe)); // Back to the SUB
		prog.push_back(alu_word(OP_ADD, 4'd14, 4'd14, 4'd4)); // Shadow twice, runs once
		prog.push_back({OP_HLT, 12'h000});
		run_program();
		finish_test("branches", errs);
	endtask

	task automatic test_hazards();
		int errs;
		errs = n_errors;
		prog.delete();
		put_const(4'd1, rand_word());
		prog.push_back(alu_word(OP_ADD, 4'd2, 4'd1, 4'd1)); // Right behind LHB r1
		prog.push_back(alu_word(OP_SUB, 4'd3, 4'd2, 4'd1));
		prog.push_back(alu_word(OP_AND, 4'd4, 4'd3, 4'd2));
		prog.push_back(alu_word(OP_SLL, 4'd5, 4'd4, 4'd3));
		prog.push_back(alu_word(OP_SW, 4'd5, 4'd0, 4'h2));
		prog.push_back(alu_word(OP_LW, 4'd6, 4'd0, 4'h2));
		prog.push_back(alu_word(OP_ADD, 4'd7, 4'd6, 4'd6)); // Load-use
		prog.push_back(alu_word(OP_SRL, 4'd8, 4'd7, 4'd1));
		prog.push_back({OP_HLT, 12'h000});
		run_program();
		finish_test("hazards", errs);
	endtask

	// Reruns the last program, whose registers do not depend on earlier state
	task automatic test_restart();
		int errs;
		errs = n_errors;
		check_halted();
		extend_budget(prog.size());
		apb_write(`REG_CTRL, 16'h0001);
		run_to_halt();
		check_halted();
		check_against_model();
		finish_test("halt_restart", errs);
	endtask

	initial begin
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= '0;
		pwdata <= '0;
		n_checks = 0;
		n_errors = 0;
		n_tests = 0;
		foreach (ref_regs[i]) ref_regs[i] = '0; // Matches the reset register file
		@(negedge rst);
		test_apb_map();
		test_alu();
		test_load_store();
		test_branches();
		test_hazards();
		test_restart();
		$display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
		if (n_errors == 0) $display("PASS: all tests");
		else $display("FAIL: see errors above");
		$finish;
	end

	// Budget grows as each program is loaded
	initial begin
		elapsed = 0;
		while (elapsed <= budget) begin
			@(posedge clk);
			elapsed++;
		end
		$display("timeout after %0d cycles, the tests did not finish", elapsed);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/tb_clock_gen.sv
// Testbench clock and reset generator: free-running clock, reset held for a few cycles
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
	parameter int period_ns = 4,
	parameter int rst_cycles = 3
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(period_ns / 2) clk = ~clk; // 50% duty
	end

	initial begin
		rst = 1'b1;
		repeat (rst_cycles) @(posedge clk);
		rst <= 1'b0; // Drops right after the last reset edge
	end

endmodule

`default_nettype wire

// File: wisc_top.sv
// WISC top: five-stage pipeline with APB host control block
`timescale 1ns/10ps
`default_nettype none

`include "wisc_consts.svh"

module wisc_top (
	input  wire logic               clk,
	input  wire logic               rst,
	input  wire logic               psel,
	input  wire logic               penable,
	input  wire logic               pwrite,
	input  wire logic [`APB_AW-1:0] paddr,
	input  wire logic [`WORD_W-1:0] pwdata,
	output logic      [`WORD_W-1:0] prdata,
	output logic                    pready,
	output logic                    pslverr
);
	import wisc_pkg::*;

	logic                run, restart, stall, halt_seen, redirect;
	logic [`WORD_W-1:0]  redirect_pc, dbg_data, imem_wdata;
	logic                imem_we;
	logic [`IMEM_AW-1:0] imem_waddr;
	logic [`REG_AW-1:0]  dbg_sel;
	ifid_t               ifid;
	idex_t               idex_d, idex_q;
	exmem_t              exmem_d, exmem_q;
	memwb_t              memwb_d, memwb_q;

	host_ctrl_regs host_ctrl_regs_inst (.clk, .rst, .psel, .penable, .pwrite, .paddr,
		.pwdata, .prdata, .pready, .pslverr,
		.retire(memwb_d.valid && !memwb_d.halt), .halt_retired(memwb_d.valid && memwb_d.halt),
		.dbg_data, .run, .restart, .imem_we, .imem_waddr, .imem_wdata, .dbg_sel);

	fetch_stage fetch_stage_inst (.clk, .rst, .run, .restart, .stall, .redirect,
		.stop_fetch(halt_seen), .redirect_pc, .imem_we, .imem_waddr, .imem_wdata, .ifid);

	decode_stage decode_stage_inst (.clk, .rst, .run, .restart, .ifid,
		.ex_dest(idex_q.dest), .ex_we(idex_q.reg_we),
		.mem_dest(exmem_q.dest), .mem_we(exmem_q.reg_we),
		.wb_dest(memwb_q.dest), .wb_we(memwb_q.reg_we),
		.wr_en(memwb_q.reg_we), .wr_addr(memwb_q.dest), .wr_data(memwb_q.data),
		.dbg_sel, .dbg_data, .idex(idex_d), .stall, .halt_seen);

	pipe_stage_reg #(.payload_t(idex_t)) idex_reg_inst (.clk, .rst, .hold(!run),
		.flush(redirect || restart), .d(idex_d), .q(idex_q));

	execute_stage execute_stage_inst (.idex(idex_q), .exmem(exmem_d), .redirect, .redirect_pc);

	pipe_stage_reg #(.payload_t(exmem_t)) exmem_reg_inst (.clk, .rst, .hold(!run),
		.flush(restart), .d(exmem_d), .q(exmem_q));

	mem_stage mem_stage_inst (.clk, .rst, .exmem(exmem_q), .memwb(memwb_d));

	pipe_stage_reg #(.payload_t(memwb_t)) memwb_reg_inst (.clk, .rst, .hold(!run),
		.flush(restart), .d(memwb_d), .q(memwb_q));

endmodule

`default_nettype wire

// File: logic/host_ctrl_regs.sv
// Host control: APB slave for run control, program load, counters, debug reads
`timescale 1ns/10ps
`default_nettype none

`include "wisc_consts.svh"

module host_ctrl_regs (
	input  wire logic                clk,
	input  wire logic                rst,
	input  wire logic                psel,
	input  wire logic                penable,
	input  wire logic                pwrite,
	input  wire logic [`APB_AW-1:0]  paddr,
	input  wire logic [`WORD_W-1:0]  pwdata,
	output logic      [`WORD_W-1:0]  prdata,
	output logic                     pready,
	output logic                     pslverr,
	input  wire logic                retire,
	input  wire logic                halt_retired,
	input  wire logic [`WORD_W-1:0]  dbg_data,
	output logic                     run,
	output logic                     restart,
	output logic                     imem_we,
	output logic      [`IMEM_AW-1:0] imem_waddr,
	output logic      [`WORD_W-1:0]  imem_wdata,
	output logic      [`REG_AW-1:0]  dbg_sel
);

	logic               access, wr, mapped, read_only;
	logic               halted;
	logic [`WORD_W-1:0] cycles, retired;

	assign access = psel && penable;
	assign pready = 1'b1; // No wait states

	always_comb begin
		mapped = 1'b1;
		read_only = 1'b0;
		prdata = '0;
		case (paddr)
			`REG_CTRL: prdata = {15'd0, run};
			`REG_STATUS: begin
				prdata = {15'd0, halted};
				read_only = 1'b1;
			end
			`REG_IMEM_ADDR: prdata = {8'd0, imem_waddr};
			`REG_IMEM_DATA: prdata = '0; // Write only
			`REG_DBG_SEL: prdata = {12'd0, dbg_sel};
			`REG_DBG_DATA: begin
				prdata = dbg_data;
				read_only = 1'b1;
			end
			`REG_CYCLES: begin
				prdata = cycles;
				read_only = 1'b1;
			end
			`REG_RETIRED: begin
				prdata = retired;
				read_only = 1'b1;
			end
			default: mapped = 1'b0;
		endcase
	end

	assign pslverr = access && (!mapped || (pwrite && read_only));
	assign wr = access && pwrite && !pslverr;
	assign imem_we = wr && paddr == `REG_IMEM_DATA;
	assign imem_wdata = pwdata;

	always_ff @(posedge clk) begin
		if (rst) begin
			run <= 1'b0;
			restart <= 1'b0;
			halted <= 1'b0;
			cycles <= '0;
			retired <= '0;
			imem_waddr <= '0;
			dbg_sel <= '0;
		end else begin
			restart <= 1'b0; // Single-cycle pulse
			if (run) cycles <= cycles + 1'b1;
			if (run && retire) retired <= retired + 1'b1;
			if (run && halt_retired) begin
				run <= 1'b0;
				halted <= 1'b1;
			end
			if (wr && paddr == `REG_CTRL) begin
				run <= pwdata[0];
				if (pwdata[0] && !run) begin // Start from PC 0
					restart <= 1'b1;
					halted <= 1'b0;
					cycles <= '0;
					retired <= '0;
				end
			end
			if (wr && paddr == `REG_IMEM_ADDR) imem_waddr <= pwdata[`IMEM_AW-1:0];
			if (imem_we) imem_waddr <= imem_waddr + 1'b1;
			if (wr && paddr == `REG_DBG_SEL) dbg_sel <= pwdata[`REG_AW-1:0];
		end
	end

	// Access phase always follows a setup phase
	a_apb_setup_first: assert property (@(posedge clk) disable iff (rst)
		$rose(penable) |-> psel && $past(psel));

endmodule

`default_nettype wire

// File: logic/mem_stage.sv
// Memory stage: data memory, load/store and write-back data select
`timescale 1ns/10ps
`default_nettype none

`include "wisc_consts.svh"

module mem_stage (
	input  wire logic             clk,
	input  wire logic             rst,
	input  wire wisc_pkg::exmem_t exmem,
	output wisc_pkg::memwb_t      memwb
);
	import wisc_pkg::*;

	logic [`WORD_W-1:0] dmem [2**`DMEM_AW];
	logic [`DMEM_AW-1:0] addr;

	assign addr = exmem.result[`DMEM_AW-1:0]; // Word address

	always_ff @(posedge clk) begin
		if (exmem.valid && exmem.store) dmem[addr] <= exmem.store_data;
	end

	always_comb begin
		memwb.valid = exmem.valid;
		memwb.halt = exmem.halt;
		memwb.dest = exmem.dest;
		memwb.reg_we = exmem.reg_we;
		memwb.data = exmem.load ? dmem[addr] : exmem.result; // Load beats ALU
	end

	a_ld_st_excl: assert property (@(posedge clk) disable iff (rst)
		!(exmem.load && exmem.store));

endmodule

`default_nettype wire

// File: execute/execute_stage.sv
// Execute stage: operand select, ALU and branch resolution
`timescale 1ns/10ps
`default_nettype none

`include "wisc_consts.svh"

module execute_stage (
	input  wire wisc_pkg::idex_t    idex,
	output wisc_pkg::exmem_t        exmem,
	output logic                    redirect,
	output logic      [`WORD_W-1:0] redirect_pc
);
	import wisc_pkg::*;

	logic [`WORD_W-1:0] b;
	logic [`WORD_W-1:0] result;
	logic               taken;

	assign b = idex.imm_sel ? idex.imm : idex.op_b;

	always_comb begin
		case (idex.alu_op)
			ALU_ADD: result = idex.op_a + b;
			ALU_SUB: result = idex.op_a - b;
			ALU_AND: result = idex.op_a & b;
			ALU_NOR: result = ~(idex.op_a | b);
			ALU_SLL: result = idex.op_a << b[3:0];
			ALU_SRL: result = idex.op_a >> b[3:0];
			ALU_LLB: result = {idex.op_a[15:8], b[7:0]}; // Keep high byte
			ALU_LHB: result = {b[7:0], idex.op_a[7:0]}; // Keep low byte
			default: result = '0;
		endcase
	end

	// Branch tests operand A
	always_comb begin
		case (idex.br_cond)
			BR_ZERO: taken = (idex.op_a == '0);
			BR_NZERO: taken = (idex.op_a != '0);
			BR_ALWAYS: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	assign redirect = idex.valid && idex.branch && taken;
	assign redirect_pc = idex.pc + 1'b1 + idex.imm; // Offset already sign-extended

	always_comb begin
		exmem.valid = idex.valid;
		exmem.load = idex.load;
		exmem.store = idex.store;
		exmem.halt = idex.halt;
		exmem.dest = idex.dest;
		exmem.reg_we = idex.reg_we;
		exmem.result = result;
		exmem.store_data = idex.op_b; // Raw rt, not the immediate
	end

endmodule

`default_nettype wire

// File: decode/decode_stage.sv
// Decode stage: control decode, write-through register file and RAW stall
`timescale 1ns/10ps
`default_nettype none

`include "wisc_consts.svh"

module decode_stage (
	input  wire logic               clk,
	input  wire logic               rst,
	input  wire logic               run,
	input  wire logic               restart,
	input  wire wisc_pkg::ifid_t    ifid,
	input  wire logic [`REG_AW-1:0] ex_dest,
	input  wire logic               ex_we,
	input  wire logic [`REG_AW-1:0] mem_dest,
	input  wire logic               mem_we,
	input  wire logic [`REG_AW-1:0] wb_dest,
	input  wire logic               wb_we,
	input  wire logic               wr_en,
	input  wire logic [`REG_AW-1:0] wr_addr,
	input  wire logic [`WORD_W-1:0] wr_data,
	input  wire logic [`REG_AW-1:0] dbg_sel,
	output logic      [`WORD_W-1:0] dbg_data,
	output wisc_pkg::idex_t         idex,
	output logic                    stall,
	output logic                    halt_seen
);
	import wisc_pkg::*;

	logic [`WORD_W-1:0] regs [2**`REG_AW];
	logic               wr_act; // Write-back happens this cycle
	opcode_e            op;
	logic [`REG_AW-1:0] ra, rb, rd; // Read ports and destination
	logic               use_a, use_b, writes;
	logic               hazard;
	logic               live; // Valid and not being restarted

	assign wr_act = wr_en && run && (wr_addr != '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 2**`REG_AW; i++) regs[i] <= '0;
		end else if (wr_act) begin
			regs[wr_addr] <= wr_data;
		end
	end

	function automatic logic [`WORD_W-1:0] rd_port(input logic [`REG_AW-1:0] a);
		if (a == '0) return '0; // r0 hardwired
		if (wr_act && wr_addr == a) return wr_data; // Write through
		return regs[a];
	endfunction

	always_comb begin
		op = opcode_e'(ifid.instr[15:12]);
		rd = ifid.instr[11:8];
		ra = ifid.instr[7:4];
		rb = ifid.instr[3:0];
		use_a = 1'b0;
		use_b = 1'b0;
		writes = 1'b0;
		idex = '0;
		idex.alu_op = ALU_ADD;
		idex.br_cond = br_cond_e'(ifid.instr[11:10]);
		idex.pc = ifid.pc;
		case (op)
			OP_ADD, OP_SUB, OP_AND, OP_NOR: begin
				use_a = 1'b1;
				use_b = 1'b1;
				writes = 1'b1;
				idex.alu_op = alu_op_e'({1'b0, op[1:0]}); // Encodings line up
			end
			OP_SLL, OP_SRL: begin
				use_a = 1'b1;
				writes = 1'b1;
				idex.imm_sel = 1'b1;
				idex.alu_op = (op == OP_SLL) ? ALU_SLL : ALU_SRL;
				idex.imm = {12'd0, ifid.instr[3:0]}; // Shift amount
			end
			OP_LW, OP_SW: begin
				use_a = 1'b1;
				idex.imm_sel = 1'b1;
				idex.imm = {{12{ifid.instr[3]}}, ifid.instr[3:0]};
				idex.load = (op == OP_LW);
				idex.store = (op == OP_SW);
				writes = (op == OP_LW);
				use_b = (op == OP_SW); // Store data in rt
				rb = ifid.instr[11:8];
			end
			OP_LLB, OP_LHB: begin
				use_a = 1'b1;
				writes = 1'b1;
				ra = ifid.instr[11:8]; // Keep the other byte of rd
				idex.imm_sel = 1'b1;
				idex.imm = {8'd0, ifid.instr[7:0]};
				idex.alu_op = (op == OP_LLB) ? ALU_LLB : ALU_LHB;
			end
			OP_B: begin
				use_a = 1'b1;
				ra = {2'b00, ifid.instr[9:8]};
				idex.branch = 1'b1;
				idex.imm = {{8{ifid.instr[7]}}, ifid.instr[7:0]};
			end
			OP_HLT: idex.halt = 1'b1;
			default: ; // Unused opcodes retire as no-ops
		endcase
		idex.op_a = rd_port(ra);
		idex.op_b = rd_port(rb);
		idex.dest = rd;

		// Pending writer in any later stage blocks issue
		hazard = 1'b0;
		if (use_a && ra != '0)
			hazard |= (ex_we && ex_dest == ra) || (mem_we && mem_dest == ra)
				|| (wb_we && wb_dest == ra);
		if (use_b && rb != '0)
			hazard |= (ex_we && ex_dest == rb) || (mem_we && mem_dest == rb)
				|| (wb_we && wb_dest == rb);

		live = ifid.valid && !restart;
		stall = live && hazard;
		idex.valid = live && !hazard; // Bubble while stalled
		idex.reg_we = idex.valid && writes && (rd != '0);
		if (!idex.valid) begin
			idex.halt = 1'b0;
			idex.branch = 1'b0;
			idex.load = 1'b0;
			idex.store = 1'b0;
		end
		halt_seen = run && idex.halt;
	end

	assign dbg_data = rd_port(dbg_sel);

	// Write-back path must never target r0
	a_no_r0_write: assert property (@(posedge clk) disable iff (rst)
		!(wr_en && wr_addr == '0));

endmodule

`default_nettype wire

// File: fetch/fetch_stage.sv
// Fetch stage: PC, instruction memory with host load port, IF/ID register
`timescale 1ns/10ps
`default_nettype none

`include "wisc_consts.svh"

module fetch_stage (
	input  wire logic               clk,
	input  wire logic               rst,
	input  wire logic               run,
	input  wire logic               restart,
	input  wire logic               stall,
	input  wire logic               redirect,
	input  wire logic               stop_fetch, // HLT in decode
	input  wire logic [`WORD_W-1:0] redirect_pc,
	input  wire logic               imem_we,
	input  wire logic [`IMEM_AW-1:0] imem_waddr,
	input  wire logic [`WORD_W-1:0] imem_wdata,
	output wisc_pkg::ifid_t         ifid
);
	import wisc_pkg::*;

	logic [`WORD_W-1:0] imem [2**`IMEM_AW]; // Program store
	logic [`WORD_W-1:0] pc;
	logic               stopped; // Past a HLT, issue bubbles

	always_ff @(posedge clk) begin
		if (imem_we) imem[imem_waddr] <= imem_wdata; // Host load only
	end

	always_ff @(posedge clk) begin
		if (rst || restart) begin
			pc <= '0;
			stopped <= 1'b0;
			ifid <= '0;
		end else if (run) begin
			if (redirect) begin // Taken branch, drop the wrong path
				pc <= redirect_pc;
				stopped <= 1'b0;
				ifid.valid <= 1'b0;
			end else if (stall) begin
				// Hold PC and IF/ID
			end else if (stopped || stop_fetch) begin
				stopped <= 1'b1;
				ifid.valid <= 1'b0;
			end else begin
				ifid.valid <= 1'b1;
				ifid.pc <= pc;
				ifid.instr <= imem[pc[`IMEM_AW-1:0]];
				pc <= pc + 1'b1;
			end
		end
	end

	// Program load happens only with the core stopped
	a_no_imem_write_running: assert property (@(posedge clk) disable iff (rst)
		!(imem_we && run));

endmodule

`default_nettype wire

// File: logic/pipe_stage_reg.sv
// Pipeline register: holds while the core is stopped, clears on flush
`timescale 1ns/10ps
`default_nettype none

module pipe_stage_reg #(
	parameter type payload_t = logic [15:0]
) (
	input  wire logic     clk,
	input  wire logic     rst,
	input  wire logic     hold,
	input  wire logic     flush,
	input  wire payload_t d,
	output payload_t      q
);

	always_ff @(posedge clk) begin
		if (rst) begin
			q <= '0;
		end else if (hold) begin
			q <= q; // Core stopped
		end else if (flush) begin
			q <= '0; // Valid drops with the rest
		end else begin
			q <= d;
		end
	end

endmodule

`default_nettype wire

// File: common/wisc_pkg.sv
// WISC package: opcodes, ALU operations, branch conditions and stage payloads
`default_nettype none

`include "wisc_consts.svh"

package wisc_pkg;

	// Instruction formats
	//   ALU     op rd rs rt          shifts use bits 3:0 as amount
	//   LW/SW   op rt rs off4        rt is dest (LW) or data (SW)
	//   LLB/LHB op rd imm8
	//   B       op cond[11:10] reg[9:8] off8 ... tests r0..r3
	typedef enum logic [3:0] {
		OP_ADD = 4'h0,
		OP_SUB = 4'h1,
		OP_AND = 4'h2,
		OP_NOR = 4'h3,
		OP_SLL = 4'h4,
		OP_SRL = 4'h5,
		OP_LW  = 4'h8,
		OP_SW  = 4'h9,
		OP_LHB = 4'ha,
		OP_LLB = 4'hb,
		OP_B   = 4'hc,
		OP_HLT = 4'hf
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD, // Also LW/SW address
		ALU_SUB,
		ALU_AND,
		ALU_NOR,
		ALU_SLL,
		ALU_SRL,
		ALU_LLB, // Byte merge into low byte
		ALU_LHB  // Byte merge into high byte
	} alu_op_e;

	typedef enum logic [1:0] {
		BR_ZERO   = 2'd0,
		BR_NZERO  = 2'd1,
		BR_ALWAYS = 2'd2 // 3 never taken
	} br_cond_e;

	typedef struct packed {
		logic               valid;
		logic [`WORD_W-1:0] pc;
		logic [`WORD_W-1:0] instr;
	} ifid_t;

	typedef struct packed {
		logic               valid;
		alu_op_e            alu_op;
		logic               imm_sel; // B operand from imm
		logic               load;
		logic               store;
		logic               branch;
		logic               halt;
		br_cond_e           br_cond;
		logic [`WORD_W-1:0] op_a;
		logic [`WORD_W-1:0] op_b;
		logic [`WORD_W-1:0] imm; // Sign-extended where signed
		logic [`REG_AW-1:0] dest;
		logic               reg_we; // Implies valid, never r0
		logic [`WORD_W-1:0] pc;
	} idex_t;

	typedef struct packed {
		logic               valid;
		logic               load;
		logic               store;
		logic               halt;
		logic [`REG_AW-1:0] dest;
		logic               reg_we;
		logic [`WORD_W-1:0] result; // ALU result or address
		logic [`WORD_W-1:0] store_data;
	} exmem_t;

	typedef struct packed {
		logic               valid;
		logic               halt;
		logic [`REG_AW-1:0] dest;
		logic               reg_we;
		logic [`WORD_W-1:0] data;
	} memwb_t;

endpackage

`default_nettype wire

// File: common/wisc_consts.svh
// WISC constants: data and address widths, memory depths and host register offsets
`ifndef WISC_CONSTS_SVH
`define WISC_CONSTS_SVH

`define WORD_W 16 // Datapath width
`define REG_AW 4 // Sixteen general registers
`define IMEM_AW 8 // 256-word instruction memory
`define DMEM_AW 8 // 256-word data memory
`define APB_AW 5 // Byte offsets, word-aligned

`define REG_CTRL 5'h00 // Bit 0 run
`define REG_STATUS 5'h04 // Bit 0 halted
`define REG_IMEM_ADDR 5'h08
`define REG_IMEM_DATA 5'h0c // Write auto-increments IMEM_ADDR
`define REG_DBG_SEL 5'h10
`define REG_DBG_DATA 5'h14
`define REG_CYCLES 5'h18
`define REG_RETIRED 5'h1c

`endif
